// File: hw/serial_regs_pkg.sv
package serial_regs_pkg;

	// ==============================
	// register map of the FF page
	// ==============================

	localparam logic [7:0] sb_offset = 8'h01; // transfer data byte
	localparam logic [7:0] sc_offset = 8'h02; // transfer control

	localparam logic [7:0] rd_open = 8'hff; // reads of unmapped offsets

	// the six unused bits of SC read back as ones
	localparam int         sc_start_bit   = 7;
	localparam int         sc_int_clk_bit = 0;
	localparam logic [7:0] sc_unused      = 8'h7e;

	// wr and rd of a bus request are single clk strobes
	typedef struct packed {
		logic       wr;
		logic       rd;
		logic       ffxx; // high while the CPU addresses FF00..FFFF
		logic [7:0] addr;
		logic [7:0] wdata;
	} cpu_req_t;

	// decoded register writes
	typedef struct packed {
		logic       sb_wr;
		logic       sc_wr;
		logic [7:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic start;   // transfer requested or running
		logic int_clk; // port drives the shift clock
	} sc_reg_t;

endpackage

// File: hw/serial_link_pkg.sv
package serial_link_pkg;

	// ==============================
	// shift clock and transfer size
	// ==============================

	localparam int sck_half  = 8; // clk cycles per half period of the internal clock
	localparam int bit_count = 8;

	localparam int sck_cnt_w = $clog2(sck_half);
	localparam int bit_cnt_w = $clog2(bit_count);

	typedef logic [sck_cnt_w-1:0] sck_cnt_t;
	typedef logic [bit_cnt_w-1:0] bit_cnt_t;

	// ==============================
	// pins and datapath control
	// ==============================

	typedef struct packed {
		logic sck_in;
		logic sin_in;
	} link_in_t;

	typedef struct packed {
		logic sck_out;
		logic sck_dir; // high when the port drives the clock
		logic ser_out;
	} link_out_t;

	typedef struct packed {
		logic load;   // take the CPU byte into SB
		logic sample; // latch sin on the rising edge of the shift clock
		logic shift;  // move a bit onto ser_out on the falling edge
	} shift_ctrl_t;

	typedef struct packed {
		logic rise;
		logic fall;
	} sck_edges_t;

endpackage

// File: hw/serial_cpu_port.sv
`timescale 1ns/1ps
`default_nettype none

module serial_cpu_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  serial_regs_pkg::cpu_req_t req,
	input  logic [7:0]               sb,
	input  serial_regs_pkg::sc_reg_t sc,
	output serial_regs_pkg::reg_wr_t wr,
	output logic [7:0]               rd_data
);

	logic       sb_hit;
	logic       sc_hit;
	logic [7:0] sc_value;

	// ==============================
	// address decode
	// ==============================

	assign sb_hit = req.ffxx && (req.addr == serial_regs_pkg::sb_offset);
	assign sc_hit = req.ffxx && (req.addr == serial_regs_pkg::sc_offset);

	always_comb begin
		wr.sb_wr = req.wr && sb_hit;
		wr.sc_wr = req.wr && sc_hit;
		wr.data  = req.wdata;
	end

	// SC as the CPU sees it
	always_comb begin
		sc_value = serial_regs_pkg::sc_unused;
		sc_value[serial_regs_pkg::sc_start_bit]   = sc.start;
		sc_value[serial_regs_pkg::sc_int_clk_bit] = sc.int_clk;
	end

	// ==============================
	// registered read port
	// ==============================

	// rd_data holds its value until the next read strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_data <= serial_regs_pkg::rd_open;
		end else if (req.rd) begin
			if (sb_hit) begin
				rd_data <= sb;
			end else if (sc_hit) begin
				rd_data <= sc_value;
			end else begin
				rd_data <= serial_regs_pkg::rd_open; // nothing else lives here
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/serial_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module serial_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	input  serial_regs_pkg::reg_wr_t     wr,
	input  serial_link_pkg::sck_edges_t  edges,
	output serial_regs_pkg::sc_reg_t     sc,
	output serial_link_pkg::shift_ctrl_t shift,
	output logic                         busy,
	output logic                         restart,
	output logic                         int_serial
);

	serial_link_pkg::bit_cnt_t bit_cnt;
	logic                      last_bit;     // eighth sample of the running transfer
	logic                      int_clk_pend; // SC was written during the transfer
	logic                      int_clk_next;
	logic                      new_int_clk;

	assign busy = sc.start;

	// a start write while idle launches a transfer
	assign restart = wr.sc_wr && !busy && wr.data[serial_regs_pkg::sc_start_bit];

	always_comb begin
		shift.load   = wr.sb_wr && !busy; // SB is locked while bits move
		shift.sample = edges.rise && busy;
		shift.shift  = edges.fall && busy;
	end

	assign last_bit = shift.sample &&
		(bit_cnt == serial_link_pkg::bit_cnt_t'(serial_link_pkg::bit_count - 1));

	// a write in the final cycle still counts as deferred
	assign new_int_clk = wr.sc_wr ? wr.data[serial_regs_pkg::sc_int_clk_bit] : int_clk_next;

	// ==============================
	// SC, bit counter and interrupt
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sc           <= '0;
			bit_cnt      <= '0;
			int_clk_pend <= 1'b0;
			int_serial   <= 1'b0;
		end else begin
			int_serial <= last_bit;
			if (!busy) begin
				if (wr.sc_wr) begin
					sc.start   <= wr.data[serial_regs_pkg::sc_start_bit];
					sc.int_clk <= wr.data[serial_regs_pkg::sc_int_clk_bit];
					bit_cnt    <= '0;
				end
			end else begin
				if (wr.sc_wr) begin
					int_clk_pend <= 1'b1;
				end
				if (shift.sample) begin
					bit_cnt <= bit_cnt + 1'b1; // wraps to zero on the last bit
				end
				if (last_bit) begin
					sc.start     <= 1'b0;
					int_clk_pend <= 1'b0;
					if (wr.sc_wr || int_clk_pend) begin
						sc.int_clk <= new_int_clk;
					end
				end
			end
		end
	end

	// value of a deferred int_clk write
	always_ff @(posedge clk) begin
		if (busy && wr.sc_wr) begin
			int_clk_next <= wr.data[serial_regs_pkg::sc_int_clk_bit];
		end
	end

endmodule

`default_nettype wire

// File: hw/serial_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module serial_clock_gen (
	input  logic                        clk,
	input  logic                        rst_n,
	input  serial_link_pkg::link_in_t   link,
	input  logic                        int_clk,
	input  logic                        busy,
	input  logic                        restart,
	output serial_link_pkg::sck_edges_t edges,
	output logic                        sck_out,
	output logic                        sck_dir
);

	serial_link_pkg::sck_cnt_t   div_cnt;
	logic                        sck_int;
	serial_link_pkg::sck_edges_t int_edges;
	serial_link_pkg::sck_edges_t ext_edges;
	logic [1:0]                  sck_sync;
	logic                        sck_prev;

	// ==============================
	// internal shift clock
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt   <= '0;
			sck_int   <= 1'b1; // idles high
			int_edges <= '0;
		end else begin
			int_edges <= '0;
			if (restart) begin
				div_cnt <= serial_link_pkg::sck_cnt_t'(1); // the SC write cycle counts
				sck_int <= 1'b1;
			end else if (busy && int_clk) begin
				if (div_cnt == serial_link_pkg::sck_cnt_t'(serial_link_pkg::sck_half - 1)) begin
					div_cnt        <= '0;
					sck_int        <= !sck_int;
					int_edges.rise <= !sck_int;
					int_edges.fall <= sck_int;
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	// ==============================
	// external shift clock
	// ==============================

	// edges come out three clk after the pin moves
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sck_sync  <= '1;
			sck_prev  <= 1'b1;
			ext_edges <= '0;
		end else begin
			sck_sync       <= {sck_sync[0], link.sck_in};
			sck_prev       <= sck_sync[1];
			ext_edges.rise <= sck_sync[1] && !sck_prev;
			ext_edges.fall <= !sck_sync[1] && sck_prev;
		end
	end

	assign edges   = int_clk ? int_edges : ext_edges;
	assign sck_out = sck_int;
	assign sck_dir = int_clk;

endmodule

`default_nettype wire

// File: hw/serial_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module serial_shifter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  serial_link_pkg::shift_ctrl_t ctl,
	input  logic [7:0]                   wdata,
	input  logic                         sin,
	output logic [7:0]                   sb,
	output logic                         ser_out
);

	logic sin_q;

	// one more flop on the input pin before it is sampled
	always_ff @(posedge clk) begin
		sin_q <= sin;
	end

	// ==============================
	// SB and output bit
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sb      <= '0;
			ser_out <= 1'b1; // line idles high
		end else begin
			if (ctl.load) begin
				sb <= wdata;
			end else if (ctl.sample) begin
				sb <= {sb[6:0], sin_q}; // MSB first with the partner bit entering at the bottom
			end
			if (ctl.shift) begin
				ser_out <= sb[7];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/serial_top.sv
`timescale 1ns/1ps
`default_nettype none

module serial_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  serial_regs_pkg::cpu_req_t  req,
	output logic [7:0]                 rd_data,
	input  serial_link_pkg::link_in_t  link,
	output serial_link_pkg::link_out_t pins,
	output logic                       int_serial
);

	serial_regs_pkg::reg_wr_t     wr;
	serial_regs_pkg::sc_reg_t     sc;
	serial_link_pkg::sck_edges_t  edges;
	serial_link_pkg::shift_ctrl_t shift;
	logic [7:0]                   sb;
	logic                         busy;
	logic                         restart;
	logic                         sck_out;
	logic                         sck_dir;
	logic                         ser_out;

	// ==============================
	// CPU side
	// ==============================

	serial_cpu_port i_cpu_port (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (req),
		.sb      (sb),
		.sc      (sc),
		.wr      (wr),
		.rd_data (rd_data)
	);

	serial_ctrl i_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr         (wr),
		.edges      (edges),
		.sc         (sc),
		.shift      (shift),
		.busy       (busy),
		.restart    (restart),
		.int_serial (int_serial)
	);

	// ==============================
	// link side
	// ==============================

	serial_clock_gen i_clock_gen (
		.clk     (clk),
		.rst_n   (rst_n),
		.link    (link),
		.int_clk (sc.int_clk),
		.busy    (busy),
		.restart (restart),
		.edges   (edges),
		.sck_out (sck_out),
		.sck_dir (sck_dir)
	);

	serial_shifter i_shifter (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctl     (shift),
		.wdata   (wr.data),
		.sin     (link.sin_in),
		.sb      (sb),
		.ser_out (ser_out)
	);

	assign pins = '{sck_out: sck_out, sck_dir: sck_dir, ser_out: ser_out};

endmodule

`default_nettype wire

// File: test/tb_serial.sv
`timescale 1ns/1ps

module tb_serial;

	logic                       clk;
	logic                       rst_n;
	serial_regs_pkg::cpu_req_t  req;
	logic [7:0]                 rd_data;
	serial_link_pkg::link_in_t  link;
	serial_link_pkg::link_out_t pins;
	logic                       int_serial;
	logic                       sck_out_w;
	logic                       ser_out_w;

	int          cyc = 0;       // clk rising edges seen so far as counted on the falling edge
	int          int_count = 0;
	int          int_cyc;
	int          sc_wr_cyc;     // edge on which the last SC write strobe was driven
	int          rise_cyc;      // edge on which the partner raised sck_in for the last bit
	int          n_cases = 0;
	logic        ext_active = 1'b0;
	logic [31:0] rng = 32'h05a32f92;
	logic [7:0]  case_mode[$];
	logic [7:0]  case_cpu[$];
	logic [7:0]  case_partner[$];

	serial_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.rd_data    (rd_data),
		.link       (link),
		.pins       (pins),
		.int_serial (int_serial)
	);

	assign sck_out_w = pins.sck_out;
	assign ser_out_w = pins.ser_out;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// interrupt and clock direction monitor
	always @(negedge clk) begin
		cyc++;
		if (int_serial) begin
			int_count++;
			int_cyc = cyc;
		end
		if (ext_active) begin
			assert (!pins.sck_dir)
			else fail_now("sck_dir went high while the partner drives the clock");
		end
	end

	// ==============================
	// helpers
	// ==============================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected)
		else fail_now($sformatf("error: %s expected 0x%0h actual 0x%0h", name, expected, actual));
	endtask

	task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		req <= '{wr: 1'b1, rd: 1'b0, ffxx: 1'b1, addr: addr, wdata: data};
		if (addr == serial_regs_pkg::sc_offset) begin
			sc_wr_cyc = cyc + 1;
		end
		@(posedge clk);
		req <= '0;
	endtask

	task automatic cpu_read(input logic [7:0] addr, output logic [7:0] data);
		@(posedge clk);
		req <= '{wr: 1'b0, rd: 1'b1, ffxx: 1'b1, addr: addr, wdata: 8'h00};
		@(posedge clk);
		req <= '0;
		@(negedge clk);
		data = rd_data; // registered on the edge after the strobe
	endtask

	task automatic wait_for_int(input int target, input int limit);
		int n;
		n = 0;
		while (int_count < target && n < limit) begin
			@(posedge clk);
			n++;
		end
		assert (int_count == target)
		else fail_now("the serial interrupt did not arrive in time");
	endtask

	// the partner puts a new bit out on each fall of the port's clock and captures on each rise
	task automatic drive_internal_link(input logic [7:0] tx, output logic [7:0] rx);
		int n;
		rx = '0;
		for (n = 7; n >= 0; n--) begin
			@(negedge sck_out_w);
			@(posedge clk);
			link.sin_in <= tx[n];
			@(posedge sck_out_w);
			@(negedge clk);
			rx = {rx[6:0], ser_out_w};
		end
	endtask

	task automatic clock_external_link(input logic [7:0] tx, output logic [7:0] rx);
		int n;
		int half;
		rx = '0;
		for (n = 7; n >= 0; n--) begin
			rng = xorshift32(rng);
			half = 20 + int'(rng % 41);
			repeat (half) @(posedge clk);
			link.sck_in <= 1'b0;
			link.sin_in <= tx[n];
			rng = xorshift32(rng);
			half = 20 + int'(rng % 41);
			repeat (half - 1) @(posedge clk);
			@(negedge clk);
			rx = {rx[6:0], ser_out_w};
			@(posedge clk);
			link.sck_in <= 1'b1;
			rise_cyc = cyc + 1;
		end
	endtask

	// nothing may move while the partner clock wiggles with start clear
	task automatic idle_gap(input int count_expect, input logic [7:0] sb_expect);
		logic       ser_before;
		logic [7:0] val;
		int         n;
		@(negedge clk);
		ser_before = ser_out_w;
		for (n = 0; n < 4; n++) begin
			repeat (12) @(posedge clk);
			link.sck_in <= 1'b0;
			link.sin_in <= ~link.sin_in;
			repeat (12) @(posedge clk);
			link.sck_in <= 1'b1;
		end
		repeat (12) @(posedge clk);
		check_value("int_serial count", int_count, count_expect);
		check_value("sck_out", sck_out_w, 1);
		check_value("ser_out", ser_out_w, ser_before);
		cpu_read(serial_regs_pkg::sb_offset, val);
		check_value("rd_data (SB after idle gap)", val, sb_expect);
	endtask

	// ==============================
	// watchdog and main sequence
	// ==============================

	initial begin
		wait (n_cases > 0);
		repeat (n_cases * 16 * 60 * 2 + 2000) @(posedge clk);
		$display("timeout: the test did not finish within the expected number of clock cycles");
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

	initial begin
		int         fd;
		int         k;
		int         base;
		logic [7:0] m;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] val;
		logic [7:0] rx;

		req   = '0;
		link  = '{sck_in: 1'b1, sin_in: 1'b1};
		rst_n = 1'b0;

		fd = $fopen("test/serial_cases.txt", "r");
		assert (fd != 0) else fail_now("could not open test/serial_cases.txt");
		while ($fscanf(fd, "%h %h %h\n", m, a, b) == 3) begin
			case_mode.push_back(m);
			case_cpu.push_back(a);
			case_partner.push_back(b);
		end
		$fclose(fd);
		assert (case_mode.size() > 0) else fail_now("the cases file holds no cases");
		n_cases = case_mode.size();

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("int_serial", int_serial, 0);
		check_value("sck_dir", pins.sck_dir, 0);
		check_value("sck_out", pins.sck_out, 1);
		check_value("ser_out", pins.ser_out, 1);
		cpu_read(serial_regs_pkg::sb_offset, val);
		check_value("rd_data (SB after reset)", val, 8'h00);
		cpu_read(serial_regs_pkg::sc_offset, val);
		check_value("rd_data (SC after reset)", val, 8'h7e);

		for (k = 0; k < n_cases; k++) begin
			cpu_write(serial_regs_pkg::sb_offset, case_cpu[k]);
			cpu_read(serial_regs_pkg::sb_offset, val);
			check_value("rd_data (SB after write)", val, case_cpu[k]);
			@(posedge clk);
			base = int_count;
			if (case_mode[k][0]) begin
				cpu_write(serial_regs_pkg::sc_offset, 8'h81); // start on the internal clock
				fork
					drive_internal_link(case_partner[k], rx);
					wait_for_int(base + 1, 16 * serial_link_pkg::sck_half + 40);
					begin
						repeat (50) @(posedge clk);
						cpu_write(serial_regs_pkg::sb_offset, ~case_cpu[k]);
					end
				join
				check_value("int_serial delay", int_cyc - sc_wr_cyc,
					16 * serial_link_pkg::sck_half + 1);
			end else begin
				cpu_write(serial_regs_pkg::sc_offset, 8'h80);
				ext_active = 1'b1; // int_clk is clear from here on
				fork
					clock_external_link(case_partner[k], rx);
					begin
						repeat (50) @(posedge clk);
						cpu_write(serial_regs_pkg::sb_offset, ~case_cpu[k]);
					end
				join
				wait_for_int(base + 1, 20);
				check_value("int_serial delay after last rise", int_cyc - rise_cyc, 4);
				ext_active = 1'b0;
			end
			check_value("partner rx", rx, case_cpu[k]);
			cpu_read(serial_regs_pkg::sb_offset, val);
			check_value("rd_data (SB after transfer)", val, case_partner[k]);
			cpu_read(serial_regs_pkg::sc_offset, val);
			check_value("rd_data (SC after transfer)", val, {1'b0, 6'h3f, case_mode[k][0]});
			idle_gap(base + 1, case_partner[k]);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: serial_link.f
hw/serial_regs_pkg.sv
hw/serial_link_pkg.sv
hw/serial_cpu_port.sv
hw/serial_ctrl.sv
hw/serial_clock_gen.sv
hw/serial_shifter.sv
hw/serial_top.sv
test/tb_serial.sv

// File: test/serial_cases.txt
1 a5 3c
0 5a c3
1 00 ff
0 ff 00
1 80 01
0 01 80
1 55 aa
0 aa 55
1 12 34
0 de ad
1 be ef
0 7e 81
1 0f f0
0 f0 0f
1 c9 36
0 3c 96
1 69 e1
0 24 db
1 fe 7f
0 7f fe
1 b7 48
0 4d 2b
1 91 6e
0 e3 1c
1 38 c7
0 d2 2d
1 46 b9
0 8f 70
1 ff ff
0 00 00
